/* all.f */
loader_pkg.sv
load_arbiter.sv
prg_injector.sv
crt_parser.sv
ram_eraser.sv
media_loader_top.sv
tb_media_loader.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the media loader testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_media_loader \
	-o tb_media_loader
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_media_loader > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
	echo "Simulation log has no result"
	exit 1
fi
exit 0

/* tb_media_loader.sv */
// Testbench for the media loader: PRG, CRT, erase and back-pressure
// Memory is modelled sparse; every write is checked as it happens
// Long run: three erases cover 256K I/O slots
`timescale 1ns/1ps

module tb_media_loader;

	localparam longint SLOT_NS = 8 * 40;
	localparam int PRG_BYTES = 2 + 63;
	localparam int CRT_BYTES = 64 + 2 * 16 + 127 + 63;
	localparam int PATCH_SLOTS = 256 / 8 + 12;
	localparam int ERASE_SLOTS = 'h20000 + 'h10000 + 'h10000;
	// A download byte takes at most two slots to be written
	localparam longint RUN_SLOTS = 2 * (2 * PRG_BYTES + CRT_BYTES + 2 * PATCH_SLOTS) + ERASE_SLOTS;
	localparam longint RUN_NS = 2 * RUN_SLOTS * SLOT_NS;

	logic clk_sys, reset_n, dl_active_i, io_cycle_i, erase_start_i;
	logic [7:0] dl_index_i;
	loader_pkg::dl_byte_s dl_byte_i;
	logic mem_we_o, ioctl_wait_o, prg_start_o, bank_wr_o, cart_attached_o, erasing_o;
	logic [24:0] mem_addr_o;
	logic [7:0] mem_data_o;
	loader_pkg::cart_info_s cart_o;
	loader_pkg::bank_rec_s bank_o;

	logic [31:0] lfsr;
	logic [7:0] mem [int];
	logic [7:0] exp_mem [int];
	int wr_cnt [int];
	loader_pkg::bank_rec_s bank_log [$];
	int err_cnt, err_mark, check_cnt, test_cnt, prg_start_cnt, erase_next, prg_in_erase;
	logic erase_d;
	logic [31:0] r;
	logic [15:0] load;
	int len;

	media_loader_top #(.MEM_AW(25)) dut_i (
		.clk_sys(clk_sys), .reset_n(reset_n), .dl_active_i(dl_active_i),
		.dl_index_i(dl_index_i), .dl_byte_i(dl_byte_i), .io_cycle_i(io_cycle_i),
		.erase_start_i(erase_start_i), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
		.mem_data_o(mem_data_o), .ioctl_wait_o(ioctl_wait_o), .prg_start_o(prg_start_o),
		.cart_o(cart_o), .bank_o(bank_o), .bank_wr_o(bank_wr_o),
		.cart_attached_o(cart_attached_o), .erasing_o(erasing_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// I/O slots, four cycles high then four low
	initial begin
		io_cycle_i = 1'b1;
		forever begin
			repeat (4) @(posedge clk_sys);
			#2;
			io_cycle_i = ~io_cycle_i;
		end
	end

	initial begin
		#(RUN_NS);
		$display("Watchdog timeout, the tests did not finish in the allowed time");
		$display("Test failed");
		$finish;
	end

	// ======================================================================
	// Reference model
	// ======================================================================

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
	endfunction

	function automatic logic [7:0] ref_erase(input int a);
		return {8{a[6]}};
	endfunction

	// BASIC pointer byte, bit 8 marks a pointer address
	function automatic logic [8:0] ref_ptr(input logic [7:0] a, input logic [15:0] s,
		input logic [15:0] e);
		case (a)
			8'h2B, 8'hAC: return {1'b1, s[7:0]};
			8'h2C, 8'hAD: return {1'b1, s[15:8]};
			8'h2D, 8'h2F, 8'h31, 8'hAE: return {1'b1, e[7:0]};
			8'h2E, 8'h30, 8'h32, 8'hAF: return {1'b1, e[15:8]};
			default: return 9'h000;
		endcase
	endfunction

	// Packet data start, rounded up to the next 8 KB after the previous packet
	function automatic int ref_crt_addr(input int prev_addr, input int prev_len);
		return (prev_addr + prev_len + 'h1FFF) & ~'h1FFF;
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = 32'd0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR @ %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	// ======================================================================
	// Compare process, sampled on the falling edge
	// ======================================================================

	always @(negedge clk_sys) begin
		if (reset_n === 1'b1) begin
			if (dl_byte_i.wr) begin
				check("strobe while ioctl_wait_o high", 32'(ioctl_wait_o), 32'd0);
			end
			if (mem_we_o) begin
				mem[int'(mem_addr_o)] = mem_data_o;
				// Eraser was pending in the cycle that picked this write
				if (erase_d) begin
					check("erase address", 32'(mem_addr_o), erase_next);
					check("erase data", 32'(mem_data_o), 32'(ref_erase(int'(mem_addr_o))));
					erase_next++;
				end else if (exp_mem.exists(int'(mem_addr_o))) begin
					check("write data", 32'(mem_data_o), 32'(exp_mem[int'(mem_addr_o)]));
					if (wr_cnt.exists(int'(mem_addr_o))) begin
						wr_cnt[int'(mem_addr_o)]++;
					end else begin
						wr_cnt[int'(mem_addr_o)] = 1;
					end
					if (erasing_o && erase_next > 0) begin
						prg_in_erase++;
					end
				end else begin
					err_cnt++;
					$display("Unexpected write of %h to address %h at %0t ns",
						mem_data_o, mem_addr_o, $time);
				end
			end
			if (prg_start_o) begin
				prg_start_cnt++;
			end
			if (bank_wr_o) begin
				bank_log.push_back(bank_o);
			end
		end
		erase_d = erasing_o;
	end

	// ======================================================================
	// Stimulus
	// ======================================================================

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic send_byte(input int ofs, input logic [7:0] d);
		while (ioctl_wait_o) begin
			next_cycle();
		end
		dl_byte_i.wr = 1'b1;
		dl_byte_i.addr = loader_pkg::ram_addr_t'(ofs);
		dl_byte_i.data = d;
		next_cycle();
		dl_byte_i.wr = 1'b0;
	endtask

	task automatic finish_download();
		while (ioctl_wait_o) begin
			next_cycle();
		end
		dl_active_i = 1'b0;
		next_cycle();
	endtask

	task automatic pulse_erase();
		erase_next = 0;
		erase_start_i = 1'b1;
		next_cycle();
		erase_start_i = 1'b0;
	endtask

	task automatic load_prg(input logic [15:0] ld, input int n, input int erase_at);
		logic [31:0] v;
		logic [8:0] p;
		logic [15:0] e;
		exp_mem.delete();
		wr_cnt.delete();
		prg_start_cnt = 0;
		prg_in_erase = 0;
		e = ld + 16'(n);
		for (int i = 0; i < 256; i++) begin
			p = ref_ptr(8'(i), ld, e);
			if (p[8]) begin
				exp_mem[i] = p[7:0];
			end
		end
		dl_index_i = {2'd0, loader_pkg::IDX_KIND_PRG};
		dl_active_i = 1'b1;
		next_cycle();
		send_byte(0, ld[7:0]);
		send_byte(1, ld[15:8]);
		for (int i = 0; i < n; i++) begin
			rand_bits(8, v);
			exp_mem[int'(ld) + i] = v[7:0];
			if (i == erase_at) begin
				pulse_erase();
			end
			send_byte(2 + i, v[7:0]);
		end
		finish_download();
		while (!prg_start_o) begin
			next_cycle();
		end
		repeat (4) next_cycle();
	endtask

	task automatic load_crt();
		logic [31:0] v;
		logic [7:0] file [$];
		int dlen [2];
		int base [2];
		logic [7:0] btype [2];
		loader_pkg::cart_info_s info;
		exp_mem.delete();
		wr_cnt.delete();
		bank_log.delete();
		rand_bits(32, v);
		info = v;
		for (int i = 0; i < 64; i++) begin
			file.push_back(8'h00);
		end
		file[8'h16] = info.id[15:8];
		file[8'h17] = info.id[7:0];
		file[8'h18] = info.exrom;
		file[8'h19] = info.game;
		for (int p = 0; p < 2; p++) begin
			rand_bits(p == 0 ? 6 : 5, v);
			dlen[p] = (p == 0 ? 64 : 32) + int'(v);
			base[p] = (p == 0) ? ref_crt_addr(int'(loader_pkg::CRT_BASE), 0) :
				ref_crt_addr(base[0], dlen[0]);
			rand_bits(2, v);
			btype[p] = v[7:0];
			// Packet header: CHIP, length incl. header, type, bank, load, size
			for (int i = 3; i >= 0; i--) begin
				file.push_back(8'(32'h43484950 >> (8 * i)));
			end
			for (int i = 3; i >= 0; i--) begin
				file.push_back(8'((dlen[p] + 16) >> (8 * i)));
			end
			file.push_back(8'h00);
			file.push_back(btype[p]);
			file.push_back(8'h00);
			file.push_back(8'(p));
			file.push_back(8'h80);
			file.push_back(8'h00);
			file.push_back(8'(dlen[p] >> 8));
			file.push_back(8'(dlen[p]));
			for (int i = 0; i < dlen[p]; i++) begin
				rand_bits(8, v);
				exp_mem[base[p] + i] = v[7:0];
				file.push_back(v[7:0]);
			end
		end
		dl_index_i = loader_pkg::IDX_CRT_B;
		dl_active_i = 1'b1;
		next_cycle();
		for (int i = 0; i < file.size(); i++) begin
			send_byte(i, file[i]);
		end
		finish_download();
		while (!cart_attached_o) begin
			next_cycle();
		end
		next_cycle();
		check("cart id", 32'(cart_o.id), 32'(info.id));
		check("cart exrom", 32'(cart_o.exrom), 32'(info.exrom));
		check("cart game", 32'(cart_o.game), 32'(info.game));
		check("bank records", bank_log.size(), 2);
		for (int p = 0; p < 2 && p < bank_log.size(); p++) begin
			check("bank type", 32'(bank_log[p].bank_type), 32'(btype[p]));
			check("bank number", 32'(bank_log[p].bank_num), p);
			check("bank load address", 32'(bank_log[p].load_addr), 32'h8000);
			check("bank size", 32'(bank_log[p].size), dlen[p]);
			check("bank ram address", 32'(bank_log[p].ram_addr), base[p]);
		end
	endtask

	task automatic run_erase(input int top);
		logic [31:0] v;
		int a;
		pulse_erase();
		check("erasing_o raised", 32'(erasing_o), 32'd1);
		while (erasing_o) begin
			next_cycle();
		end
		check("erase writes", erase_next, top + 1);
		for (int k = 0; k < 16; k++) begin
			rand_bits(17, v);
			a = int'(v) & top;
			check("erased byte", 32'(mem[a]), 32'(ref_erase(a)));
		end
	endtask

	task automatic check_range(input string what, input int lo, input int hi, input bit with_mem);
		foreach (exp_mem[a]) begin
			if (a >= lo && a <= hi) begin
				check({what, " written once"}, wr_cnt.exists(a) ? wr_cnt[a] : 0, 32'd1);
				if (with_mem) begin
					check({what, " in memory"}, 32'(mem[a]), 32'(exp_mem[a]));
				end
			end
		end
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		if (err_cnt == err_mark) begin
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			$display("test %0d %s: FAIL, %0d errors", test_cnt, name, err_cnt - err_mark);
		end
		err_mark = err_cnt;
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		reset_n = 1'b0;
		dl_active_i = 1'b0;
		dl_index_i = 8'h00;
		dl_byte_i = '0;
		erase_start_i = 1'b0;
		lfsr = 32'h23b;
		err_cnt = 0;
		err_mark = 0;
		check_cnt = 0;
		test_cnt = 0;
		erase_next = 0;
		repeat (4) @(posedge clk_sys);
		#2;
		reset_n = 1'b1;
		next_cycle();
		check("mem_we_o after reset", 32'(mem_we_o), 32'd0);
		check("ioctl_wait_o after reset", 32'(ioctl_wait_o), 32'd0);
		check("prg_start_o after reset", 32'(prg_start_o), 32'd0);
		check("bank_wr_o after reset", 32'(bank_wr_o), 32'd0);
		check("erasing_o after reset", 32'(erasing_o), 32'd0);
		check("cart_attached_o after reset", 32'(cart_attached_o), 32'd0);
		end_test("reset state");

		rand_bits(12, r);
		load = {4'h1, r[11:0]};
		rand_bits(5, r);
		len = 16 + int'(r);
		load_prg(load, len, -1);
		check_range("PRG data", int'(load), 'hFFFF, 1'b1);
		end_test("PRG data placement");
		check_range("PRG pointer", 0, 'hFF, 1'b1);
		check("prg_start_o pulses", prg_start_cnt, 32'd1);
		end_test("PRG pointer patch");

		load_crt();
		check_range("CRT data", int'(loader_pkg::CRT_BASE), 'h1FFFFFF, 1'b1);
		end_test("CRT header and bank records");

		// First erase also clears the cartridge RAM area
		run_erase('h1FFFF);
		run_erase('hFFFF);
		end_test("erase");

		rand_bits(12, r);
		load = {4'h2, r[11:0]};
		rand_bits(5, r);
		len = 16 + int'(r);
		load_prg(load, len, len / 2);
		check_range("PRG data", int'(load), 'hFFFF, 1'b0);
		check_range("PRG pointer", 0, 'hFF, 1'b0);
		check("erase writes", erase_next, 32'h10000);
		check("PRG writes inside erase", prg_in_erase, 32'd0);
		check("prg_start_o pulses", prg_start_cnt, 32'd1);
		end_test("back-pressure and priority");

		$display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* media_loader_top.sv */
// Media loader: PRG injector, cartridge parser and RAM eraser on one
// memory write port, paced by the machine's I/O slots
// Host must not strobe a byte while ioctl_wait_o is high
`timescale 1ns/1ps

module media_loader_top #(
	parameter int MEM_AW = loader_pkg::MEM_AW_DEF
) (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  logic                   dl_active_i,
	input  logic [7:0]             dl_index_i,
	input  loader_pkg::dl_byte_s   dl_byte_i,
	input  logic                   io_cycle_i,
	input  logic                   erase_start_i,
	output logic                   mem_we_o,
	output logic [MEM_AW-1:0]      mem_addr_o,
	output logic [7:0]             mem_data_o,
	output logic                   ioctl_wait_o,
	output logic                   prg_start_o,
	output loader_pkg::cart_info_s cart_o,
	output loader_pkg::bank_rec_s  bank_o,
	output logic                   bank_wr_o,
	output logic                   cart_attached_o,
	output logic                   erasing_o
);

	loader_pkg::mem_req_s erase_req;
	loader_pkg::mem_req_s prg_req;
	loader_pkg::mem_req_s crt_req;
	logic                 erase_gnt;
	logic                 prg_gnt;
	logic                 crt_gnt;
	logic                 cram_clear;

	load_arbiter #(.MEM_AW(MEM_AW)) arbiter_i (
		.clk_sys(clk_sys), .reset_n(reset_n), .io_cycle_i(io_cycle_i),
		.erase_req_i(erase_req), .prg_req_i(prg_req), .crt_req_i(crt_req),
		.erase_gnt_o(erase_gnt), .prg_gnt_o(prg_gnt), .crt_gnt_o(crt_gnt),
		.mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o), .mem_data_o(mem_data_o),
		.ioctl_wait_o(ioctl_wait_o)
	);

	prg_injector #(.MEM_AW(MEM_AW)) prg_i (
		.clk_sys(clk_sys), .reset_n(reset_n), .dl_active_i(dl_active_i),
		.dl_index_i(dl_index_i), .dl_byte_i(dl_byte_i), .gnt_i(prg_gnt),
		.req_o(prg_req), .prg_start_o(prg_start_o)
	);

	// Parser raises the cartridge RAM clear for the next erase
	crt_parser #(.MEM_AW(MEM_AW)) crt_i (
		.clk_sys(clk_sys), .reset_n(reset_n), .dl_active_i(dl_active_i),
		.dl_index_i(dl_index_i), .dl_byte_i(dl_byte_i), .gnt_i(crt_gnt),
		.req_o(crt_req), .cart_o(cart_o), .bank_o(bank_o), .bank_wr_o(bank_wr_o),
		.cart_attached_o(cart_attached_o), .cram_clear_o(cram_clear)
	);

	ram_eraser #(.MEM_AW(MEM_AW)) eraser_i (
		.clk_sys(clk_sys), .reset_n(reset_n), .erase_start_i(erase_start_i),
		.cram_clear_i(cram_clear), .gnt_i(erase_gnt),
		.req_o(erase_req), .erasing_o(erasing_o)
	);

endmodule

/* ram_eraser.sv */
// Fills RAM with the power-on pattern, every byte is address bit 6 repeated
// Top is 0xFFFF, or 0x1FFFF for the erase that follows a cartridge load
`timescale 1ns/1ps

module ram_eraser #(
	parameter int MEM_AW = loader_pkg::MEM_AW_DEF
) (
	input  logic                 clk_sys,
	input  logic                 reset_n,
	input  logic                 erase_start_i,
	input  logic                 cram_clear_i,
	input  logic                 gnt_i,
	output loader_pkg::mem_req_s req_o,
	output logic                 erasing_o
);

	logic [MEM_AW-1:0] cur_addr;
	logic [MEM_AW-1:0] top_addr;
	logic              cram_pend;
	logic              at_top;

	assign at_top = (cur_addr == top_addr);

	// Request stays up for the whole walk
	always_comb begin
		req_o.req  = erasing_o;
		req_o.addr = loader_pkg::ram_addr_t'(cur_addr);
		req_o.data = {8{cur_addr[6]}};
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			erasing_o <= 1'b0;
			cram_pend <= 1'b0;
		end else begin
			if (cram_clear_i) begin
				cram_pend <= 1'b1;
			end
			if (erase_start_i && !erasing_o) begin
				erasing_o <= 1'b1;
				cur_addr  <= '0;
				top_addr  <= cram_pend ? MEM_AW'(loader_pkg::ERASE_TOP_CRAM) :
					MEM_AW'(loader_pkg::ERASE_TOP_RAM);
			end
			if (gnt_i) begin
				if (at_top) begin
					erasing_o <= 1'b0;
					if (top_addr == MEM_AW'(loader_pkg::ERASE_TOP_CRAM) && !cram_clear_i) begin
						cram_pend <= 1'b0;
					end
				end else begin
					cur_addr <= cur_addr + 1'b1;
				end
			end
		end
	end

endmodule

/* crt_parser.sv */
// Cartridge image parser: file header, chip packets, bank records
// Packet data goes from CRT_BASE up, each packet starting on an 8 KB boundary
// Packet lengths under 16 bytes are not supported
`timescale 1ns/1ps

module crt_parser #(
	parameter int MEM_AW = loader_pkg::MEM_AW_DEF
) (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  logic                   dl_active_i,
	input  loader_pkg::dl_index_u  dl_index_i,
	input  loader_pkg::dl_byte_s   dl_byte_i,
	input  logic                   gnt_i,
	output loader_pkg::mem_req_s   req_o,
	output loader_pkg::cart_info_s cart_o,
	output loader_pkg::bank_rec_s  bank_o,
	output logic                   bank_wr_o,
	output logic                   cart_attached_o,
	output logic                   cram_clear_o
);

	logic              sel_crt;
	logic              crt_wr;
	logic              crt_dl;
	logic              dl_active_d;
	logic [MEM_AW-1:0] wr_addr;
	logic [31:0]       blk_len;
	logic [3:0]        hdr_cnt;
	logic [7:0]        din;

	assign sel_crt = (dl_index_i.raw == loader_pkg::IDX_CRT_A) ||
		(dl_index_i.raw == loader_pkg::IDX_CRT_B);
	assign crt_wr = dl_active_i & dl_byte_i.wr & sel_crt;
	assign din    = dl_byte_i.data;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			req_o.req       <= 1'b0;
			bank_wr_o       <= 1'b0;
			cart_attached_o <= 1'b0;
			cram_clear_o    <= 1'b0;
			crt_dl          <= 1'b0;
			dl_active_d     <= 1'b0;
			hdr_cnt         <= 4'd0;
		end else begin
			dl_active_d  <= dl_active_i;
			bank_wr_o    <= 1'b0;
			cram_clear_o <= 1'b0;
			if (dl_active_i) begin
				crt_dl <= sel_crt;
			end

			if (gnt_i) begin
				req_o.req <= 1'b0;
				wr_addr   <= wr_addr + 1'b1;
			end

			// ==============================================================
			// File header
			// ==============================================================
			if (crt_wr) begin
				if (dl_byte_i.addr == 'h0) begin
					wr_addr <= MEM_AW'(loader_pkg::CRT_BASE);
					blk_len <= 32'd0;
					hdr_cnt <= 4'd0;
				end
				if (dl_byte_i.addr == 'h16) cart_o.id[15:8] <= din;
				if (dl_byte_i.addr == 'h17) cart_o.id[7:0]  <= din;
				if (dl_byte_i.addr == 'h18) cart_o.exrom    <= din;
				if (dl_byte_i.addr == 'h19) cart_o.game     <= din;

				// ==========================================================
				// Chip packets
				// ==========================================================
				if (dl_byte_i.addr >= 'h40) begin
					if (blk_len == 32'd0 && hdr_cnt == 4'd0) begin
						// First header byte, move to the next 8 KB boundary
						hdr_cnt <= 4'd1;
						if (wr_addr[12:0] != 13'd0) begin
							wr_addr <= {wr_addr[MEM_AW-1:13] + 1'b1, 13'd0};
						end
					end else if (hdr_cnt != 4'd0) begin
						hdr_cnt <= hdr_cnt + 1'b1;
						case (hdr_cnt)
							4'd4:  blk_len[31:24] <= din;
							4'd5:  blk_len[23:16] <= din;
							4'd6:  blk_len[15:8]  <= din;
							4'd7:  blk_len[7:0]   <= din;
							// Length field counts the 16 header bytes too
							4'd8:  blk_len <= blk_len - 32'd16;
							4'd9:  bank_o.bank_type <= din;
							4'd10: bank_o.bank_num[15:8] <= din;
							4'd11: bank_o.bank_num[7:0]  <= din;
							4'd12: bank_o.load_addr[15:8] <= din;
							4'd13: bank_o.load_addr[7:0]  <= din;
							4'd14: bank_o.size[15:8] <= din;
							4'd15: begin
								bank_o.size[7:0] <= din;
								bank_o.ram_addr  <= loader_pkg::ram_addr_t'(wr_addr);
								bank_wr_o        <= 1'b1;
							end
							default: ;
						endcase
					end else begin
						blk_len    <= blk_len - 1'b1;
						req_o.req  <= 1'b1;
						req_o.addr <= loader_pkg::ram_addr_t'(wr_addr);
						req_o.data <= din;
					end
				end
			end

			// Attach state follows the download edges
			if (dl_active_i && !dl_active_d && sel_crt) begin
				cart_attached_o <= 1'b0;
			end
			if (!dl_active_i && dl_active_d && crt_dl) begin
				cart_attached_o <= 1'b1;
				cram_clear_o    <= 1'b1;
			end
		end
	end

endmodule

/* prg_injector.sv */
// Loads a PRG image at the address in its first two bytes
// After the download, patches the BASIC pointers in zero page and pulses
// prg_start_o; the load address is 16 bits, upper address bits are zero
`timescale 1ns/1ps

module prg_injector #(
	parameter int MEM_AW = loader_pkg::MEM_AW_DEF
) (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  logic                  dl_active_i,
	input  loader_pkg::dl_index_u dl_index_i,
	input  loader_pkg::dl_byte_s  dl_byte_i,
	input  logic                  gnt_i,
	output loader_pkg::mem_req_s  req_o,
	output logic                  prg_start_o
);

	logic              sel_prg;
	logic              data_wr;
	logic              prg_dl;
	logic              dl_active_d;
	logic [MEM_AW-1:0] wr_addr;
	logic [15:0]       start_ptr;
	logic [15:0]       end_ptr;
	logic              patching;
	logic              req_patch;
	logic [8:0]        patch_addr;
	logic              patch_end;
	logic              ptr_hit;
	logic [7:0]        ptr_val;

	assign sel_prg = (dl_index_i.k.kind == loader_pkg::IDX_KIND_PRG) &&
		(dl_index_i.k.subtype == 2'd0);
	assign data_wr   = dl_active_i & dl_byte_i.wr & sel_prg;
	assign patch_end = patching & ~req_o.req & patch_addr[8];

	// BASIC pointer table
	always_comb begin
		ptr_hit = 1'b1;
		case (patch_addr[7:0])
			8'h2B, 8'hAC:               ptr_val = start_ptr[7:0];
			8'h2C, 8'hAD:               ptr_val = start_ptr[15:8];
			8'h2D, 8'h2F, 8'h31, 8'hAE: ptr_val = end_ptr[7:0];
			8'h2E, 8'h30, 8'h32, 8'hAF: ptr_val = end_ptr[15:8];
			default: begin
				ptr_hit = 1'b0;
				ptr_val = 8'h00;
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			req_o.req   <= 1'b0;
			req_patch   <= 1'b0;
			patching    <= 1'b0;
			prg_dl      <= 1'b0;
			dl_active_d <= 1'b0;
			prg_start_o <= 1'b0;
		end else begin
			dl_active_d <= dl_active_i;
			prg_start_o <= patch_end;
			if (dl_active_i) begin
				prg_dl <= sel_prg;
			end

			// Grant retires the pending write
			if (gnt_i) begin
				req_o.req <= 1'b0;
				if (req_patch) begin
					patch_addr <= patch_addr + 1'b1;
				end else begin
					wr_addr <= wr_addr + 1'b1;
				end
			end

			// ==============================================================
			// Download bytes
			// ==============================================================
			if (data_wr) begin
				if (dl_byte_i.addr == 'h0) begin
					wr_addr        <= MEM_AW'(dl_byte_i.data);
					start_ptr[7:0] <= dl_byte_i.data;
					end_ptr[7:0]   <= dl_byte_i.data;
				end else if (dl_byte_i.addr == 'h1) begin
					wr_addr[15:8]   <= dl_byte_i.data;
					start_ptr[15:8] <= dl_byte_i.data;
					end_ptr[15:8]   <= dl_byte_i.data;
				end else begin
					req_o.req  <= 1'b1;
					req_patch  <= 1'b0;
					req_o.addr <= loader_pkg::ram_addr_t'(wr_addr);
					req_o.data <= dl_byte_i.data;
					end_ptr    <= end_ptr + 1'b1;
				end
			end

			// ==============================================================
			// Zero page patch pass
			// ==============================================================
			if (dl_active_d && !dl_active_i && prg_dl) begin
				patching   <= 1'b1;
				patch_addr <= 9'd0;
			end

			// Last data write must drain before the pass moves
			if (patching && !req_o.req) begin
				if (patch_addr[8]) begin
					patching <= 1'b0;
				end else if (ptr_hit) begin
					req_o.req  <= 1'b1;
					req_patch  <= 1'b1;
					req_o.addr <= loader_pkg::ram_addr_t'(patch_addr);
					req_o.data <= ptr_val;
				end else begin
					patch_addr <= patch_addr + 1'b1;
				end
			end
		end
	end

endmodule

/* load_arbiter.sv */
// Shares the single memory write port among the loader peers
// One write per I/O slot; a slot starts on the falling edge of io_cycle_i
// Fixed priority, eraser first, then PRG injector, then cartridge parser
`timescale 1ns/1ps

module load_arbiter #(
	parameter int MEM_AW = loader_pkg::MEM_AW_DEF
) (
	input  logic                 clk_sys,
	input  logic                 reset_n,
	input  logic                 io_cycle_i,
	input  loader_pkg::mem_req_s erase_req_i,
	input  loader_pkg::mem_req_s prg_req_i,
	input  loader_pkg::mem_req_s crt_req_i,
	output logic                 erase_gnt_o,
	output logic                 prg_gnt_o,
	output logic                 crt_gnt_o,
	output logic                 mem_we_o,
	output logic [MEM_AW-1:0]    mem_addr_o,
	output logic [7:0]           mem_data_o,
	output logic                 ioctl_wait_o
);

	logic                 io_cycle_d;
	logic                 slot_start;
	logic                 pick_erase;
	logic                 pick_prg;
	logic                 pick_crt;
	loader_pkg::mem_req_s sel_req;

	assign slot_start = io_cycle_d & ~io_cycle_i;

	// Priority select
	always_comb begin
		pick_erase = erase_req_i.req;
		pick_prg   = prg_req_i.req & ~erase_req_i.req;
		pick_crt   = crt_req_i.req & ~erase_req_i.req & ~prg_req_i.req;
		sel_req    = '0;
		if (pick_erase) begin
			sel_req = erase_req_i;
		end else if (pick_prg) begin
			sel_req = prg_req_i;
		end else if (pick_crt) begin
			sel_req = crt_req_i;
		end
	end

	// Write strobe and grants land in the cycle after the slot start
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_cycle_d  <= 1'b0;
			mem_we_o    <= 1'b0;
			erase_gnt_o <= 1'b0;
			prg_gnt_o   <= 1'b0;
			crt_gnt_o   <= 1'b0;
		end else begin
			io_cycle_d  <= io_cycle_i;
			mem_we_o    <= slot_start & sel_req.req;
			erase_gnt_o <= slot_start & pick_erase;
			prg_gnt_o   <= slot_start & pick_prg;
			crt_gnt_o   <= slot_start & pick_crt;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (slot_start && sel_req.req) begin
			mem_addr_o <= MEM_AW'(sel_req.addr);
			mem_data_o <= sel_req.data;
		end
	end

	// Host must hold off while a download byte is still unwritten
	assign ioctl_wait_o = prg_req_i.req | crt_req_i.req;

endmodule

/* loader_pkg.sv */
// Shared constants and packed types for the media loader
// Request and download addresses are MEM_AW_DEF bits wide; modules with a
// different MEM_AW cast at their boundary

package loader_pkg;

	// ======================================================================
	// Address map
	// ======================================================================

	localparam int MEM_AW_DEF = 25;

	typedef logic [MEM_AW_DEF-1:0] ram_addr_t;

	// Cartridge packets are stored from here up
	localparam ram_addr_t CRT_BASE = 25'h100000;

	// Last erase address, plain RAM and RAM plus cartridge RAM area
	localparam ram_addr_t ERASE_TOP_RAM  = 25'h00FFFF;
	localparam ram_addr_t ERASE_TOP_CRAM = 25'h01FFFF;

	// ======================================================================
	// Download index codes
	// ======================================================================

	// Cartridge files use the whole index byte
	localparam logic [7:0] IDX_CRT_A = 8'h05;
	localparam logic [7:0] IDX_CRT_B = 8'hC0;

	// PRG files are matched on the kind field only, subtype 0
	localparam logic [5:0] IDX_KIND_PRG = 6'd4;

	typedef struct packed {
		logic [1:0] subtype;
		logic [5:0] kind;
	} dl_kind_s;

	// Index byte seen either whole or as subtype/kind
	typedef union packed {
		logic [7:0] raw;
		dl_kind_s   k;
	} dl_index_u;

	// ======================================================================
	// Transfer records
	// ======================================================================

	// One strobe from the host download port
	typedef struct packed {
		logic       wr;
		ram_addr_t  addr;
		logic [7:0] data;
	} dl_byte_s;

	// A peer's pending write, held until granted
	typedef struct packed {
		logic       req;
		ram_addr_t  addr;
		logic [7:0] data;
	} mem_req_s;

	typedef struct packed {
		logic [15:0] id;
		logic [7:0]  exrom;
		logic [7:0]  game;
	} cart_info_s;

	// Chip packet header fields plus where its data landed
	typedef struct packed {
		logic [7:0]  bank_type;
		logic [15:0] bank_num;
		logic [15:0] load_addr;
		logic [15:0] size;
		ram_addr_t   ram_addr;
	} bank_rec_s;

endpackage
